// File: laser_board_ctrl.f
laser_pkg.sv
ram_eraser.sv
load_port.sv
mem_arbiter.sv
audio_dac.sv
laser_board_ctrl.sv
laser_board_ctrl_checker.sv
laser_board_ctrl_monitor.sv
tb_laser_board_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wall
TOP       ?= tb_laser_board_ctrl
FILELIST  ?= laser_board_ctrl.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "RESULT: FAIL" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_laser_board_ctrl.sv
// Testbench top; clock, reset, watchdog and a stimulus table applied in a loop to the board glue
`timescale 1ns/1ps

module tb_laser_board_ctrl;
	import laser_pkg::*;

	localparam logic [RAM_AW-1:0] T_START = 25'h0C000;
	localparam logic [RAM_AW-1:0] T_END   = 25'h0C010;
	localparam logic [2:0]        T_SLOT  = 3'd6;
	localparam int NUM          = 17;
	localparam int ENTRY_CYCLES = int'(T_END - T_START) * 8 + 100; // Erase range times slots, plus margin

	typedef enum logic [2:0] {OP_LOAD, OP_BOOT, OP_HOLD, OP_ERASE, OP_PRIO, OP_AUDIO} op_e;
	typedef struct packed {
		op_e               op;
		logic [RAM_AW-1:0] addr;
		logic [7:0]        data;
		logic              key, power, buzzer, cas_in, cas_out;
		logic              exp_blank, exp_cpu, exp_mix;
	} entry_t;

	logic       F14M, rst;
	logic       load_req, load_active, load_ack, erase_trigger, power_on, reset_key;
	load_byte_t load_byte;
	mem_req_t   machine_req, mem_req;
	logic [2:0] slot;
	logic       buzzer, cas_out, cas_in_raw, blank, cpu_reset, audio_l, audio_r;
	logic       hold_chk, exp_blank, exp_cpu, audio_chk, exp_mix;
	int         err_count, check_count;
	entry_t     tbl [NUM];

	laser_board_ctrl #(.ERASE_START(T_START), .ERASE_END(T_END), .ERASE_SLOT(T_SLOT))
	laser_board_ctrl_inst (.*);

	laser_board_ctrl_monitor #(.ERASE_START(T_START), .ERASE_END(T_END), .ERASE_SLOT(T_SLOT))
	monitor_inst (.*);

	always #10 F14M = ~F14M;

	// Free-running bus slot and random machine traffic, never wr and rd together
	always @(posedge F14M) begin
		logic [9:0] ctl;                   // Data byte, then rd, then wr
		ctl  = 10'($urandom());
		slot <= slot + 1'b1;
		machine_req <= '{addr: RAM_AW'($urandom()), data: ctl[7:0],
			wr: ~ctl[8] & ctl[9], rd: ctl[8]};
	end

	initial begin
		#(NUM * ENTRY_CYCLES * 20);
		$display("Timeout: the DUT stopped answering before the table finished");
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic load_one(input logic [RAM_AW-1:0] addr, input logic [7:0] data);
		@(posedge F14M);
		load_byte <= '{addr: addr, data: data};
		load_req  <= 1'b1;
		do @(posedge F14M); while (!load_ack);
		load_req <= 1'b0;
		do @(posedge F14M); while (load_ack);  // Ack drops one cycle after req
	endtask

	task automatic hold_check(input logic b, input logic c);
		repeat (2) @(posedge F14M);
		exp_blank <= b;
		exp_cpu   <= c;
		hold_chk  <= 1'b1;
		@(posedge F14M);
		hold_chk <= 1'b0;
	endtask

	task automatic erase_sweep(input logic with_load, input entry_t e);
		@(posedge F14M);
		erase_trigger <= 1'b1;
		do @(posedge F14M); while (!blank);
		erase_trigger <= 1'b0;
		if (with_load) begin
			// Req now, write offered two edges later in the eraser slot
			do @(posedge F14M); while (slot != 3'd4);
			load_byte <= '{addr: e.addr, data: e.data};
			load_req  <= 1'b1;
			do @(posedge F14M); while (!load_ack);
			load_req <= 1'b0;
		end
		do @(posedge F14M); while (blank);
	endtask

	task automatic audio_window(input entry_t e);
		@(posedge F14M);
		buzzer     <= e.buzzer;
		cas_in_raw <= e.cas_in;
		cas_out    <= e.cas_out;
		repeat (4) @(posedge F14M);            // Sync flops and DAC settle
		exp_mix   <= e.exp_mix;
		audio_chk <= 1'b1;
		@(posedge F14M);
		audio_chk <= 1'b0;
		repeat (66) @(posedge F14M);
	endtask

	initial begin
		void'($urandom(32'h5de66c6c));
		F14M          = 0;
		rst           = 1;
		slot          = 0;
		machine_req   = '0;
		load_req      = 0;
		load_byte     = '0;
		load_active   = 1;
		erase_trigger = 0;
		power_on      = 0;
		reset_key     = 0;
		buzzer        = 0;
		cas_out       = 1;
		cas_in_raw    = 1;
		hold_chk      = 0;
		exp_blank     = 1;
		exp_cpu       = 1;
		audio_chk     = 0;
		exp_mix       = 0;
		// op, addr, data, key, power, buzzer, cas_in, cas_out, blank, cpu, mix
		tbl[0]  = '{OP_LOAD,  25'h00100, 8'h3E, 0, 0, 0, 1, 1, 1, 1, 0};
		tbl[1]  = '{OP_LOAD,  25'h00101, 8'hC3, 0, 0, 0, 1, 1, 1, 1, 0};
		tbl[2]  = '{OP_LOAD,  25'h07FFF, 8'h5A, 0, 0, 0, 1, 1, 1, 1, 0};
		tbl[3]  = '{OP_LOAD,  25'h1FFFFFF, 8'hFF, 0, 0, 0, 1, 1, 1, 1, 0};
		tbl[4]  = '{OP_BOOT,  25'h0, 8'h00, 0, 0, 0, 1, 1, 0, 0, 0};
		tbl[5]  = '{OP_HOLD,  25'h0, 8'h00, 1, 0, 0, 1, 1, 0, 1, 0};
		tbl[6]  = '{OP_HOLD,  25'h0, 8'h00, 0, 1, 0, 1, 1, 0, 1, 0};
		tbl[7]  = '{OP_HOLD,  25'h0, 8'h00, 1, 1, 0, 1, 1, 0, 1, 0};
		tbl[8]  = '{OP_HOLD,  25'h0, 8'h00, 0, 0, 0, 1, 1, 0, 0, 0};
		tbl[9]  = '{OP_ERASE, 25'h0, 8'h00, 0, 0, 0, 1, 1, 0, 0, 0};
		tbl[10] = '{OP_PRIO,  25'h00200, 8'hA5, 0, 0, 0, 1, 1, 0, 0, 0};
		tbl[11] = '{OP_AUDIO, 25'h0, 8'h00, 0, 0, 0, 1, 1, 0, 0, 0};
		tbl[12] = '{OP_AUDIO, 25'h0, 8'h00, 0, 0, 1, 1, 1, 0, 0, 1};
		tbl[13] = '{OP_AUDIO, 25'h0, 8'h00, 0, 0, 0, 0, 1, 0, 0, 1};
		tbl[14] = '{OP_AUDIO, 25'h0, 8'h00, 0, 0, 0, 1, 0, 0, 0, 1};
		tbl[15] = '{OP_AUDIO, 25'h0, 8'h00, 0, 0, 1, 0, 0, 0, 0, 1};
		tbl[16] = '{OP_AUDIO, 25'h0, 8'h00, 0, 0, 1, 0, 1, 0, 0, 0}; // Buzzer and tape cancel
		repeat (3) @(posedge F14M);
		rst <= 1'b0;
		hold_check(1'b1, 1'b1);               // Still booting
		for (int i = 0; i < NUM; i++) begin
			case (tbl[i].op)
				OP_LOAD: load_one(tbl[i].addr, tbl[i].data);
				OP_BOOT: begin
					@(posedge F14M);
					load_active <= 1'b0;
					hold_check(tbl[i].exp_blank, tbl[i].exp_cpu);
				end
				OP_HOLD: begin
					@(posedge F14M);
					reset_key <= tbl[i].key;
					power_on  <= tbl[i].power;
					hold_check(tbl[i].exp_blank, tbl[i].exp_cpu);
				end
				OP_ERASE: erase_sweep(1'b0, tbl[i]);
				OP_PRIO:  erase_sweep(1'b1, tbl[i]);
				default:  audio_window(tbl[i]);
			endcase
		end
		repeat (4) @(posedge F14M);
		$display("Checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: laser_board_ctrl_monitor.sv
// Watches the DUT ports, runs a cycle model of port, handshake and holds, and counts mismatches
`timescale 1ns/1ps

module laser_board_ctrl_monitor import laser_pkg::*; #(
	parameter logic [RAM_AW-1:0] ERASE_START = ERASE_START_DEF,
	parameter logic [RAM_AW-1:0] ERASE_END   = ERASE_END_DEF,
	parameter logic [2:0]        ERASE_SLOT  = ERASE_SLOT_DEF
) (
	input  logic       F14M,
	input  logic       rst,
	input  logic       load_req,
	input  load_byte_t load_byte,
	input  logic       load_active,
	input  logic       load_ack,
	input  logic       erase_trigger,
	input  logic       power_on,
	input  logic       reset_key,
	input  mem_req_t   machine_req,
	input  logic [2:0] slot,
	input  mem_req_t   mem_req,
	input  logic       blank,
	input  logic       cpu_reset,
	input  logic       audio_l,
	input  logic       audio_r,
	input  logic       hold_chk,          // Strobe from the table, compare holds now
	input  logic       exp_blank,
	input  logic       exp_cpu,
	input  logic       audio_chk,         // Strobe, start a 64-cycle density window
	input  logic       exp_mix,
	output int         err_count,
	output int         check_count
);

	logic [1:0]        ld_state;          // 0 wait, 1 write, 2 wait drop
	logic              ack_m, ld_wr_m, er_wr_m;
	logic              er_busy, trig_q, act_q, boot_m, blank_n;
	logic [RAM_AW-1:0] er_addr;
	mem_req_t          exp_req, next_req;
	logic              blank_m, cpu_m, mix_q;
	logic              post_rst;          // First cycle out of reset
	int                win_left, ones, ones_now;

	assign ld_wr_m  = (ld_state == 2'd1);
	assign er_wr_m  = er_busy && (slot == ERASE_SLOT); // Eraser asks in its slot only
	assign blank_n  = ~boot_m | load_active | er_busy;
	assign ones_now = ones + int'(audio_l);

	// Loader beats eraser beats machine; machine is muted during a sweep
	always_comb begin
		next_req = machine_req;
		if (ld_wr_m)
			next_req = '{addr: load_byte.addr, data: load_byte.data, wr: 1'b1, rd: 1'b0};
		else if (er_wr_m)
			next_req = '{addr: er_addr, data: 8'h00, wr: 1'b1, rd: 1'b0};
		else if (er_busy) begin
			next_req.wr = 1'b0;
			next_req.rd = 1'b0;
		end
	end

	task automatic report(input string msg);
		err_count++;
		$display("FAILED at %0t: %s", $time, msg);
	endtask

	initial begin
		err_count   = 0;
		check_count = 0;
		win_left    = 0;
		ones        = 0;
	end

	always @(posedge F14M) begin
		if (rst) begin
			ld_state <= 2'd0;
			ack_m    <= 1'b0;
			er_busy  <= 1'b0;
			er_addr  <= ERASE_START;
			trig_q   <= 1'b0;
			act_q    <= 1'b0;
			boot_m   <= 1'b0;
			exp_req  <= '0;            // Idle port after reset
			blank_m  <= 1'b1;
			cpu_m    <= 1'b1;
			post_rst <= 1'b1;
		end else begin
			check_count++;
			if (mem_req !== exp_req)
				report($sformatf("mem_req %h, expected %h", mem_req, exp_req));
			if (load_ack !== ack_m) report($sformatf("load_ack %b, expected %b", load_ack, ack_m));
			if (blank !== blank_m) report($sformatf("blank %b, expected %b", blank, blank_m));
			if (cpu_reset !== cpu_m) report($sformatf("cpu_reset %b, expected %b", cpu_reset, cpu_m));
			if (audio_r !== audio_l) report("audio_r differs from audio_l");
			if (post_rst && audio_l !== 1'b0)
				report($sformatf("audio_l %b right after reset, expected 0", audio_l));
			if (hold_chk && (blank !== exp_blank || cpu_reset !== exp_cpu))
				report($sformatf("holds %b/%b, table wants %b/%b", blank, cpu_reset, exp_blank, exp_cpu));
			post_rst <= 1'b0;

			exp_req <= next_req;
			case (ld_state)             // Four-phase receiver
				2'd0: if (load_req && !ack_m) ld_state <= 2'd1;
				2'd1: begin
					ack_m    <= 1'b1;
					ld_state <= 2'd2;
				end
				default: if (!load_req) begin
					ack_m    <= 1'b0;
					ld_state <= 2'd0;
				end
			endcase

			trig_q <= erase_trigger;
			if (!er_busy) begin
				if (erase_trigger && !trig_q) begin
					er_busy <= 1'b1;
					er_addr <= ERASE_START;
				end
			end else if (er_wr_m && !ld_wr_m) begin   // Granted only if loader is quiet
				if (er_addr == ERASE_END - 1'b1) er_busy <= 1'b0;
				else er_addr <= er_addr + 1'b1;
			end

			act_q <= load_active;
			if (act_q && !load_active) boot_m <= 1'b1; // Sticky until rst
			blank_m <= blank_n;
			cpu_m   <= blank_n | reset_key | power_on;
		end
	end

	// Density window on audio_l
	always @(posedge F14M) begin
		if (audio_chk) begin
			win_left <= 64;
			ones     <= 0;
			mix_q    <= exp_mix;
		end else if (win_left > 0) begin
			ones     <= ones_now;
			win_left <= win_left - 1;
			if (win_left == 1) begin
				check_count++;
				if (mix_q ? (ones_now < 31 || ones_now > 33) : (ones_now != 0))
					report($sformatf("audio density %0d/64 for mix %b", ones_now, mix_q));
			end
		end
	end

endmodule

// File: laser_board_ctrl_checker.sv
// Bound assertions on the loader handshake, memory port and hold outputs; attached by bind below
`timescale 1ns/1ps

module laser_board_ctrl_checker import laser_pkg::*; (
	input logic     F14M,
	input logic     rst,
	input logic     load_req,
	input logic     load_ack,
	input mem_req_t mem_req,
	input logic     blank,
	input logic     cpu_reset
);

	// Ack only answers a pending request
	ack_needs_req: assert property (@(posedge F14M) disable iff (rst)
		$rose(load_ack) |-> load_req)
		else $error("load_ack rose without load_req");

	// A port cycle is a read or a write, never both
	no_wr_and_rd: assert property (@(posedge F14M) disable iff (rst)
		!(mem_req.wr && mem_req.rd))
		else $error("mem_req has wr and rd high together");

	blank_holds_cpu: assert property (@(posedge F14M) disable iff (rst) blank |-> cpu_reset)
		else $error("blank high while cpu_reset is low");

	// Port and handshake come out of reset idle
	idle_after_rst: assert property (@(posedge F14M) $fell(rst) |-> (!mem_req.wr && !load_ack))
		else $error("write or ack active right after reset");

endmodule

bind laser_board_ctrl laser_board_ctrl_checker checker_inst (
	.F14M(F14M), .rst(rst), .load_req(load_req), .load_ack(load_ack),
	.mem_req(mem_req), .blank(blank), .cpu_reset(cpu_reset)
);

// File: laser_board_ctrl.sv
// Board glue top; wires loader, eraser, arbiter and audio DAC around the shared RAM port
`timescale 1ns/1ps

module laser_board_ctrl import laser_pkg::*; #(
	parameter logic [RAM_AW-1:0] ERASE_START = ERASE_START_DEF,
	parameter logic [RAM_AW-1:0] ERASE_END   = ERASE_END_DEF,
	parameter logic [2:0]        ERASE_SLOT  = ERASE_SLOT_DEF,
	parameter int                DAC_BITS    = DAC_BITS_DEF
) (
	input  logic       F14M,
	input  logic       rst,
	// Loader
	input  logic       load_req,
	input  load_byte_t load_byte,
	input  logic       load_active,
	output logic       load_ack,
	// Reset sources
	input  logic       erase_trigger,
	input  logic       power_on,
	input  logic       reset_key,
	// Machine bus
	input  mem_req_t   machine_req,
	input  logic [2:0] slot,
	// Audio sources
	input  logic       buzzer,
	input  logic       cas_out,
	input  logic       cas_in_raw,
	// Outputs
	output mem_req_t   mem_req,
	output logic       blank,
	output logic       cpu_reset,
	output logic       audio_l,
	output logic       audio_r
);

	logic              load_wr;
	load_byte_t        load_wr_byte;
	logic              boot_done;
	logic              erase_busy;
	logic              erase_wr;
	logic [RAM_AW-1:0] erase_addr;
	logic              erase_grant;

	ram_eraser #(.ERASE_START(ERASE_START), .ERASE_END(ERASE_END), .ERASE_SLOT(ERASE_SLOT))
	ram_eraser_inst (
		.F14M(F14M), .rst(rst), .trigger(erase_trigger), .slot(slot), .grant(erase_grant),
		.busy(erase_busy), .wr(erase_wr), .addr(erase_addr)
	);

	load_port load_port_inst (
		.F14M(F14M), .rst(rst), .req(load_req), .byte_in(load_byte), .active(load_active),
		.ack(load_ack), .wr(load_wr), .wr_byte(load_wr_byte), .boot_done(boot_done)
	);

	mem_arbiter mem_arbiter_inst (
		.F14M(F14M), .rst(rst), .load_wr(load_wr), .load_byte(load_wr_byte),
		.erase_busy(erase_busy), .erase_wr(erase_wr), .erase_addr(erase_addr),
		.machine_req(machine_req), .boot_done(boot_done), .load_active(load_active),
		.reset_key(reset_key), .power_on(power_on), .erase_grant(erase_grant),
		.mem_req(mem_req), .blank(blank), .cpu_reset(cpu_reset)
	);

	audio_dac #(.DAC_BITS(DAC_BITS)) audio_dac_inst (
		.F14M(F14M), .rst(rst), .buzzer(buzzer), .cas_out(cas_out), .cas_in_raw(cas_in_raw),
		.audio_l(audio_l), .audio_r(audio_r)
	);

endmodule

// File: audio_dac.sv
// Audio path; syncs tape input, mixes buzzer and tape bits, first-order sigma-delta to both pins
`timescale 1ns/1ps

module audio_dac import laser_pkg::*; #(
	parameter int DAC_BITS = DAC_BITS_DEF
) (
	input  logic F14M,
	input  logic rst,
	input  logic buzzer,                  // Keyboard speaker bit
	input  logic cas_out,                 // Tape save line
	input  logic cas_in_raw,              // Tape input, async and active low
	output logic audio_l,
	output logic audio_r
);

	logic [1:0]          cas_sync;        // Two-flop synchronizer
	logic                cas_in;
	logic                mix;
	logic [DAC_BITS-1:0] acc;             // Sigma-delta accumulator
	logic [DAC_BITS-1:0] step;
	logic [DAC_BITS:0]   sum;             // One extra bit for the carry
	logic                dac_q;

	// Active low input, so invert after the second flop
	assign cas_in = ~cas_sync[1];

	// Tape monitor and save line share the speaker
	assign mix = buzzer ^ cas_in ^ ~cas_out;

	// Half scale when the mix bit is set, so the carry toggles every cycle
	assign step = {mix, {(DAC_BITS-1){1'b0}}};
	assign sum  = {1'b0, acc} + {1'b0, step};

	always_ff @(posedge F14M) begin
		if (rst) begin
			cas_sync <= 2'b11;           // Line idles high
		end else begin
			cas_sync <= {cas_sync[0], cas_in_raw};
		end
	end

	always_ff @(posedge F14M) begin
		if (rst) begin
			acc   <= '0;
			dac_q <= 1'b0;
		end else begin
			acc   <= sum[DAC_BITS-1:0];
			dac_q <= sum[DAC_BITS];     // Carry out is the pulse stream
		end
	end

	// Mono source on both channels
	assign audio_l = dac_q;
	assign audio_r = dac_q;

endmodule

// File: mem_arbiter.sv
// Memory port arbiter; loader, eraser, machine by fixed priority, registered out, plus blank/reset holds
`timescale 1ns/1ps

module mem_arbiter import laser_pkg::*; (
	input  logic              F14M,
	input  logic              rst,
	input  logic              load_wr,
	input  load_byte_t        load_byte,
	input  logic              erase_busy,
	input  logic              erase_wr,
	input  logic [RAM_AW-1:0] erase_addr,
	input  mem_req_t          machine_req,
	input  logic              boot_done,
	input  logic              load_active,
	input  logic              reset_key,
	input  logic              power_on,
	output logic              erase_grant,
	output mem_req_t          mem_req,
	output logic              blank,
	output logic              cpu_reset
);

	mem_owner_e owner;
	mem_req_t   req_next;
	logic       blank_next;

	// Fixed priority, loader first
	always_comb begin
		if (load_wr)
			owner = OWN_LOADER;
		else if (erase_wr)
			owner = OWN_ERASER;
		else
			owner = OWN_MACHINE;
	end

	assign erase_grant = (owner == OWN_ERASER);

	always_comb begin
		case (owner)
			OWN_LOADER:  req_next = '{addr: load_byte.addr, data: load_byte.data, wr: 1'b1, rd: 1'b0};
			OWN_ERASER:  req_next = '{addr: erase_addr, data: ERASE_FILL, wr: 1'b1, rd: 1'b0};
			default: begin
				req_next = machine_req;
				// Sweep running, machine stays off the port
				if (erase_busy) begin
					req_next.wr = 1'b0;
					req_next.rd = 1'b0;
				end
			end
		endcase
	end

	// Video stays dark until boot and during loads or sweeps
	assign blank_next = ~boot_done | load_active | erase_busy;

	always_ff @(posedge F14M) begin
		if (rst) begin
			mem_req   <= '0;               // Idle port
			blank     <= 1'b1;
			cpu_reset <= 1'b1;
		end else begin
			mem_req   <= req_next;
			blank     <= blank_next;
			cpu_reset <= blank_next | reset_key | power_on; // Blank implies reset
		end
	end

endmodule

// File: load_port.sv
// Loader receiver; four-phase req/ack handshake, one RAM write per byte, and boot-done flag
`timescale 1ns/1ps

module load_port import laser_pkg::*; (
	input  logic       F14M,
	input  logic       rst,
	input  logic       req,               // Loader request, held until ack
	input  load_byte_t byte_in,           // Stable while req is high
	input  logic       active,            // High while a download runs
	output logic       ack,
	output logic       wr,                // One-cycle write strobe
	output load_byte_t wr_byte,
	output logic       boot_done
);

	load_state_e state;
	logic        active_q;

	// Write strobe is the WRITE state itself, exactly one cycle per byte
	assign wr = (state == LOAD_WRITE);

	// Byte is stable under req, the arbiter samples it while wr is high
	assign wr_byte = byte_in;

	always_ff @(posedge F14M) begin
		if (rst) begin
			state <= LOAD_WAIT_REQ;
			ack   <= 1'b0;
		end else begin
			case (state)
				LOAD_WAIT_REQ: begin
					if (req && !ack)
						state <= LOAD_WRITE;         // Write next cycle
				end
				LOAD_WRITE: begin
					ack   <= 1'b1;               // Ack one cycle after the write
					state <= LOAD_WAIT_DROP;
				end
				LOAD_WAIT_DROP: begin
					// Wait for the loader to let go
					if (!req) begin
						ack   <= 1'b0;
						state <= LOAD_WAIT_REQ;
					end
				end
				default: begin
					state <= LOAD_WAIT_REQ;
					ack   <= 1'b0;
				end
			endcase
		end
	end

	// Boot completes on the first falling edge of active, sticky until rst
	always_ff @(posedge F14M) begin
		if (rst) begin
			active_q  <= 1'b0;
			boot_done <= 1'b0;
		end else begin
			active_q <= active;
			if (active_q && !active)
				boot_done <= 1'b1;
		end
	end

endmodule

// File: ram_eraser.sv
// RAM clear engine; on a trigger edge it writes the fill byte over a range, one byte per granted slot
`timescale 1ns/1ps

module ram_eraser import laser_pkg::*; #(
	parameter logic [RAM_AW-1:0] ERASE_START = ERASE_START_DEF,
	parameter logic [RAM_AW-1:0] ERASE_END   = ERASE_END_DEF,
	parameter logic [2:0]        ERASE_SLOT  = ERASE_SLOT_DEF
) (
	input  logic              F14M,
	input  logic              rst,
	input  logic              trigger,     // Level reset request
	input  logic [2:0]        slot,        // Machine bus slot counter
	input  logic              grant,       // Arbiter took our write this cycle
	output logic              busy,
	output logic              wr,
	output logic [RAM_AW-1:0] addr
);

	erase_state_e state;
	logic         trigger_q;               // Previous trigger for edge detect
	logic         trigger_rise;
	logic         last_addr;

	assign trigger_rise = trigger & ~trigger_q;
	assign last_addr    = (addr == ERASE_END - 1'b1);

	// Busy for the whole sweep, so the arbiter keeps the machine off the port
	assign busy = (state == ERASE_RUN);

	// Only ask in our own slot
	assign wr = busy && (slot == ERASE_SLOT);

	always_ff @(posedge F14M) begin
		if (rst) begin
			state     <= ERASE_IDLE;
			trigger_q <= 1'b0;
			addr      <= ERASE_START;
		end else begin
			trigger_q <= trigger;
			case (state)
				ERASE_IDLE: begin
					// Edges during a run fall through to the other branch and are lost
					if (trigger_rise) begin
						state <= ERASE_RUN;
						addr  <= ERASE_START;    // Restart at the bottom every time
					end
				end
				ERASE_RUN: begin
					if (wr && grant) begin
						if (last_addr)
							state <= ERASE_IDLE; // Final byte written
						else
							addr <= addr + 1'b1;
					end
					// Not granted: hold addr, try again next slot
				end
				default: state <= ERASE_IDLE;
			endcase
		end
	end

endmodule

// File: laser_pkg.sv
// Shared widths, defaults, request structs and FSM states for the board glue; import where needed
package laser_pkg;

	// RAM geometry
	parameter int RAM_AW = 25;                       // Byte address width of the shared RAM

	// Eraser defaults, pages of 16K
	parameter logic [RAM_AW-1:0] ERASE_START_DEF = 25'h0C000; // Page 3
	parameter logic [RAM_AW-1:0] ERASE_END_DEF   = 25'h20000; // Page 8, one past the end
	parameter logic [2:0]        ERASE_SLOT_DEF  = 3'd6;      // Bus slot given to the eraser
	parameter logic [7:0]        ERASE_FILL      = 8'h00;     // Value left in cleared RAM

	// Audio
	parameter int DAC_BITS_DEF = 16;                 // Sigma-delta accumulator width

	// One memory request on the shared port
	typedef struct packed {
		logic [RAM_AW-1:0] addr;
		logic [7:0]        data;                     // Write data, ignored on reads
		logic              wr;
		logic              rd;
	} mem_req_t;

	// One program byte from the loader
	typedef struct packed {
		logic [RAM_AW-1:0] addr;
		logic [7:0]        data;
	} load_byte_t;

	// Who owns the memory port this cycle
	typedef enum logic [1:0] {
		OWN_LOADER,
		OWN_ERASER,
		OWN_MACHINE
	} mem_owner_e;

	typedef enum logic {
		ERASE_IDLE,
		ERASE_RUN
	} erase_state_e;

	typedef enum logic [1:0] {
		LOAD_WAIT_REQ,                               // Idle, ack low
		LOAD_WRITE,                                  // Byte goes out to the arbiter
		LOAD_WAIT_DROP                               // Ack high until req falls
	} load_state_e;

endpackage
